/* src/glay_ctrl_pkg.sv */
// Control state encoding and run length type for the kernel control chain
`default_nettype none

package glay_ctrl_pkg;

  // --------------------
  // Control states
  // --------------------

  // Setup holds until the request FIFO leaves its reset busy window
  // Idle waits on ap_start, busy runs the job, done waits on ap_continue
  typedef enum logic [1:0] {
    SETUP = 2'b00,
    IDLE  = 2'b01,
    BUSY  = 2'b10,
    DONE  = 2'b11
  } ctrl_state_t;

  // --------------------
  // Job timing
  // --------------------

  // Run length in ap_clk cycles
  // Comes from the job descriptor, one value per job
  typedef logic [15:0] cycle_count_t;

endpackage : glay_ctrl_pkg

`default_nettype wire

/* src/glay_req_pkg.sv */
// Request word type, requester index type and requester count
`default_nettype none

package glay_req_pkg;

  // --------------------
  // Request path
  // --------------------

  // Fixed two requesters in front of the request FIFO
  localparam int unsigned NUM_REQUESTERS = 2;

  // One request word, typically a vertex index
  typedef logic [31:0] req_word_t;

  // Index of the requester that supplied a word
  // One bit covers both requesters
  typedef logic req_source_t;

endpackage : glay_req_pkg

`default_nettype wire

/* src/glay_control_input.sv */
// Control strobe input registers and job descriptor holding register
`timescale 1ns/1ps
`default_nettype none

module glay_control_input
  import glay_ctrl_pkg::*;
(
  input  logic         ap_clk               ,
  input  logic         m_axi_areset         ,
  input  logic         ap_start             ,
  input  logic         ap_continue          ,
  input  logic         descriptor_valid     ,
  input  cycle_count_t descriptor_run_cycles,
  input  logic         desc_release         ,
  output logic         start_q              ,
  output logic         continue_q           ,
  output logic         desc_held            ,
  output cycle_count_t desc_run_cycles
);

  // --------------------
  // Control strobes
  // --------------------

  // One cycle delay on start and continue
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      start_q    <= 1'b0;
      continue_q <= 1'b0;
    end else begin
      start_q    <= ap_start;
      continue_q <= ap_continue;
    end
  end

  // --------------------
  // Descriptor hold
  // --------------------

  // Held flag set by the strobe, cleared by release from control
  // A new strobe wins over a release in the same cycle
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      desc_held <= 1'b0;
    end else if (descriptor_valid) begin
      desc_held <= 1'b1;
    end else if (desc_release) begin
      desc_held <= 1'b0;
    end
  end

  // Payload, overwritten by any later descriptor
  always_ff @(posedge ap_clk) begin
    if (descriptor_valid) begin
      desc_run_cycles <= descriptor_run_cycles;
    end
  end

endmodule : glay_control_input

`default_nettype wire

/* src/glay_kernel_control.sv */
// Control chain FSM with completion timer and registered ap_* outputs
`timescale 1ns/1ps
`default_nettype none

module glay_kernel_control
  import glay_ctrl_pkg::*;
(
  input  logic         ap_clk         ,
  input  logic         m_axi_areset   ,
  input  logic         start_q        ,
  input  logic         continue_q     ,
  input  logic         desc_held      ,
  input  cycle_count_t desc_run_cycles,
  input  logic         fifo_ready     ,
  output logic         desc_release   ,
  output logic         ap_ready       ,
  output logic         ap_idle        ,
  output logic         ap_done
);

  // --------------------
  // Timer
  // --------------------

  ctrl_state_t  state       ;
  cycle_count_t timer       ;
  cycle_count_t timer_next  ;
  logic         run_complete;

  // Cycles counted so far including this one
  assign timer_next = timer + cycle_count_t'(1);

  // Last counted cycle of the job
  // A zero run length also finishes on the first counted cycle
  assign run_complete = (timer_next >= desc_run_cycles);

  // --------------------
  // Control FSM
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      state        <= SETUP;
      timer        <= '0;
      ap_ready     <= 1'b0;
      ap_idle      <= 1'b1;
      ap_done      <= 1'b0;
      desc_release <= 1'b0;
    end else begin
      // Single cycle pulses by default
      ap_ready     <= 1'b0;
      desc_release <= 1'b0;

      case (state)
        SETUP: begin
          // Wait out the FIFO reset busy window
          if (fifo_ready) begin
            state <= IDLE;
          end
        end

        IDLE: begin
          timer <= '0;
          if (start_q) begin
            // Accept the job, ready for one cycle
            state    <= BUSY;
            ap_ready <= 1'b1;
            ap_idle  <= 1'b0;
          end
        end

        BUSY: begin
          // Count only while a descriptor is held
          if (desc_held) begin
            if (run_complete) begin
              state        <= DONE;
              timer        <= '0;
              ap_done      <= 1'b1;
              desc_release <= 1'b1;
            end else begin
              timer <= timer_next;
            end
          end
        end

        DONE: begin
          // Done holds until the host continues
          if (continue_q) begin
            state   <= IDLE;
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
          end
        end

        default: begin
          state <= SETUP;
        end
      endcase
    end
  end

endmodule : glay_kernel_control

`default_nettype wire

/* src/glay_req_arbiter.sv */
// Two input round robin request arbiter feeding the request FIFO
`timescale 1ns/1ps
`default_nettype none

module glay_req_arbiter
  import glay_req_pkg::*;
(
  input  logic                      ap_clk                   ,
  input  logic                      m_axi_areset             ,
  input  logic [NUM_REQUESTERS-1:0] req_valid                ,
  input  req_word_t                 req_data [NUM_REQUESTERS],
  input  logic                      can_push                 ,
  output logic [NUM_REQUESTERS-1:0] req_grant                ,
  output logic                      push                     ,
  output req_word_t                 push_data                ,
  output req_source_t               push_source
);

  req_source_t last_winner;
  req_source_t pick       ;

  // --------------------
  // Selection
  // --------------------

  // Requester that lost last time gets first pick
  // Otherwise the last winner keeps the slot if it is the only one valid
  always_comb begin
    if (req_valid[~last_winner]) begin
      pick = ~last_winner;
    end else begin
      pick = last_winner;
    end
  end

  // Push whenever anyone asks and the FIFO takes it
  assign push        = can_push & (|req_valid);
  assign push_data   = req_data[pick];
  assign push_source = pick;

  // Grant is a pulse alongside the push
  always_comb begin
    for (int i = 0; i < NUM_REQUESTERS; i++) begin
      req_grant[i] = push && (pick == req_source_t'(i));
    end
  end

  // --------------------
  // Round robin pointer
  // --------------------

  // Reset to requester 1 so requester 0 wins first
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      last_winner <= req_source_t'(1);
    end else if (push) begin
      last_winner <= pick;
    end
  end

endmodule : glay_req_arbiter

`default_nettype wire

/* src/glay_req_fifo.sv */
// Ordered request FIFO, first word fall through, with a reset busy window
`timescale 1ns/1ps
`default_nettype none

module glay_req_fifo
  import glay_req_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH             = 8,
  parameter int unsigned FIFO_RESET_BUSY_CYCLES = 4
) (
  input  logic        ap_clk      ,
  input  logic        m_axi_areset,
  input  logic        push        ,
  input  req_word_t   push_data   ,
  input  req_source_t push_source ,
  input  logic        out_pop     ,
  output logic        can_push    ,
  output logic        fifo_ready  ,
  output logic        out_valid   ,
  output req_word_t   out_data    ,
  output req_source_t out_source
);

  localparam int unsigned ADDR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned BUSY_W = $clog2(FIFO_RESET_BUSY_CYCLES + 1);

  // Storage, word and source side by side
  req_word_t   word_mem [FIFO_DEPTH];
  req_source_t src_mem  [FIFO_DEPTH];

  logic [ADDR_W-1:0] wr_ptr  ;
  logic [ADDR_W-1:0] rd_ptr  ;
  logic [ADDR_W:0]   count   ;
  logic [BUSY_W-1:0] busy_cnt;
  logic              do_push ;
  logic              do_pop  ;

  // --------------------
  // Reset busy window
  // --------------------

  // Down counter from reset, ready once it runs out
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      busy_cnt   <= BUSY_W'(FIFO_RESET_BUSY_CYCLES);
      fifo_ready <= 1'b0;
    end else begin
      if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
      fifo_ready <= (busy_cnt <= BUSY_W'(1));
    end
  end

  // --------------------
  // Status
  // --------------------

  // Busy or full blocks the arbiter
  assign can_push  = fifo_ready & (count != (ADDR_W+1)'(FIFO_DEPTH));
  assign out_valid = fifo_ready & (count != '0);

  // Stray pushes and pops are ignored
  assign do_push = push & can_push;
  assign do_pop  = out_pop & out_valid;

  // Head of queue straight to the output
  assign out_data   = word_mem[rd_ptr];
  assign out_source = src_mem[rd_ptr];

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Power of two depth, pointers wrap by themselves
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (!do_push && do_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      word_mem[wr_ptr] <= push_data;
      src_mem[wr_ptr]  <= push_source;
    end
  end

endmodule : glay_req_fifo

`default_nettype wire

/* src/glay_kernel_cu.sv */
// Kernel compute unit top, control chain and request path wiring
`timescale 1ns/1ps
`default_nettype none

module glay_kernel_cu
  import glay_ctrl_pkg::*;
  import glay_req_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH             = 8,
  parameter int unsigned FIFO_RESET_BUSY_CYCLES = 4
) (
  input  logic                      ap_clk                   ,
  input  logic                      m_axi_areset             ,
  input  logic                      ap_start                 ,
  input  logic                      ap_continue              ,
  input  logic                      descriptor_valid         ,
  input  cycle_count_t              descriptor_run_cycles    ,
  input  logic [NUM_REQUESTERS-1:0] req_valid                ,
  input  req_word_t                 req_data [NUM_REQUESTERS],
  input  logic                      out_pop                  ,
  output logic                      ap_ready                 ,
  output logic                      ap_idle                  ,
  output logic                      ap_done                  ,
  output logic [NUM_REQUESTERS-1:0] req_grant                ,
  output logic                      out_valid                ,
  output req_word_t                 out_data                 ,
  output req_source_t               out_source
);

  // --------------------
  // Internal wires
  // --------------------

  // Control side
  logic         start_q        ;
  logic         continue_q     ;
  logic         desc_held      ;
  cycle_count_t desc_run_cycles;
  logic         desc_release   ;

  // Request side
  logic         fifo_ready ;
  logic         can_push   ;
  logic         push       ;
  req_word_t    push_data  ;
  req_source_t  push_source;

  // --------------------
  // Control chain
  // --------------------

  glay_control_input inst_glay_control_input (
    .ap_clk               (ap_clk               ),
    .m_axi_areset         (m_axi_areset         ),
    .ap_start             (ap_start             ),
    .ap_continue          (ap_continue          ),
    .descriptor_valid     (descriptor_valid     ),
    .descriptor_run_cycles(descriptor_run_cycles),
    .desc_release         (desc_release         ),
    .start_q              (start_q              ),
    .continue_q           (continue_q           ),
    .desc_held            (desc_held            ),
    .desc_run_cycles      (desc_run_cycles      )
  );

  // Leaves setup once the FIFO is ready
  glay_kernel_control inst_glay_kernel_control (
    .ap_clk         (ap_clk         ),
    .m_axi_areset   (m_axi_areset   ),
    .start_q        (start_q        ),
    .continue_q     (continue_q     ),
    .desc_held      (desc_held      ),
    .desc_run_cycles(desc_run_cycles),
    .fifo_ready     (fifo_ready     ),
    .desc_release   (desc_release   ),
    .ap_ready       (ap_ready       ),
    .ap_idle        (ap_idle        ),
    .ap_done        (ap_done        )
  );

  // --------------------
  // Request path
  // --------------------

  glay_req_arbiter inst_glay_req_arbiter (
    .ap_clk      (ap_clk      ),
    .m_axi_areset(m_axi_areset),
    .req_valid   (req_valid   ),
    .req_data    (req_data    ),
    .can_push    (can_push    ),
    .req_grant   (req_grant   ),
    .push        (push        ),
    .push_data   (push_data   ),
    .push_source (push_source )
  );

  // Read port is the unit output stream
  glay_req_fifo #(
    .FIFO_DEPTH            (FIFO_DEPTH            ),
    .FIFO_RESET_BUSY_CYCLES(FIFO_RESET_BUSY_CYCLES)
  ) inst_glay_req_fifo (
    .ap_clk      (ap_clk      ),
    .m_axi_areset(m_axi_areset),
    .push        (push        ),
    .push_data   (push_data   ),
    .push_source (push_source ),
    .out_pop     (out_pop     ),
    .can_push    (can_push    ),
    .fifo_ready  (fifo_ready  ),
    .out_valid   (out_valid   ),
    .out_data    (out_data    ),
    .out_source  (out_source  )
  );

endmodule : glay_kernel_cu

`default_nettype wire

/* bench/glay_clock_gen.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module glay_clock_gen #(
  parameter int unsigned HALF_PERIOD_NS = 10,
  parameter int unsigned RESET_CYCLES   = 3
) (
  output logic ap_clk      ,
  output logic m_axi_areset
);

  // Free running clock, 20 ns period
  initial begin
    ap_clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) ap_clk = ~ap_clk;
    end
  end

  // Reset over a fixed count of rising edges
  // Released on a falling edge, clear of the sampling edge
  initial begin
    m_axi_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    @(negedge ap_clk);
    m_axi_areset = 1'b0;
  end

endmodule : glay_clock_gen

`default_nettype wire

/* bench/glay_kernel_cu_tb.sv */
// Kernel compute unit testbench with job and traffic tables and a queue model
`timescale 1ns/1ps
`default_nettype none

module glay_kernel_cu_tb
  import glay_ctrl_pkg::*;
  import glay_req_pkg::*;
();

  localparam int unsigned FIFO_DEPTH             = 4;
  localparam int unsigned FIFO_RESET_BUSY_CYCLES = 6;
  localparam int unsigned SETUP_ENTRY            = 7;

  // --------------------
  // Stimulus tables
  // --------------------

  // Jobs: run length and idle cycles between ap_ready and the descriptor
  localparam int unsigned NUM_JOBS = 3;
  cycle_count_t job_run   [NUM_JOBS] = '{16'd1, 16'd12, 16'd37};
  int unsigned  job_delay [NUM_JOBS] = '{0, 3, 5};

  // Traffic: pattern and length in cycles
  localparam int unsigned MODE_ALTERNATE    = 0;
  localparam int unsigned MODE_BACKPRESSURE = 1;
  localparam int unsigned MODE_RANDOM       = 2;
  localparam int unsigned NUM_TRAFFIC       = 3;
  int unsigned traffic_mode   [NUM_TRAFFIC] = '{MODE_ALTERNATE, MODE_BACKPRESSURE, MODE_RANDOM};
  int unsigned traffic_cycles [NUM_TRAFFIC] = '{24, 16, 200};

  // --------------------
  // DUT signals
  // --------------------

  logic                      ap_clk, m_axi_areset;
  logic                      ap_start, ap_continue, descriptor_valid;
  cycle_count_t              descriptor_run_cycles;
  logic [NUM_REQUESTERS-1:0] req_valid, req_grant;
  req_word_t                 req_data [NUM_REQUESTERS];
  logic                      out_pop, out_valid;
  logic                      ap_ready, ap_idle, ap_done;
  req_word_t                 out_data;
  req_source_t               out_source;

  // Bookkeeping
  int unsigned error_count = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;
  int unsigned edges_since_reset = 0;
  int unsigned accepted = 0;
  int unsigned popped = 0;
  int unsigned sent [NUM_REQUESTERS] = '{default: 0};
  int          seed = 32'h022d2d61;
  ctrl_state_t phase = SETUP;
  req_source_t last_src = 1'b1;

  // Reference queue of accepted words
  req_word_t   q_word [$];
  req_source_t q_src  [$];

  glay_clock_gen clock_gen (
    .ap_clk      (ap_clk      ),
    .m_axi_areset(m_axi_areset)
  );

  glay_kernel_cu #(
    .FIFO_DEPTH            (FIFO_DEPTH            ),
    .FIFO_RESET_BUSY_CYCLES(FIFO_RESET_BUSY_CYCLES)
  ) uut (
    .ap_clk               (ap_clk               ),
    .m_axi_areset         (m_axi_areset         ),
    .ap_start             (ap_start             ),
    .ap_continue          (ap_continue          ),
    .descriptor_valid     (descriptor_valid     ),
    .descriptor_run_cycles(descriptor_run_cycles),
    .req_valid            (req_valid            ),
    .req_data             (req_data             ),
    .out_pop              (out_pop              ),
    .ap_ready             (ap_ready             ),
    .ap_idle              (ap_idle              ),
    .ap_done              (ap_done              ),
    .req_grant            (req_grant            ),
    .out_valid            (out_valid            ),
    .out_data             (out_data             ),
    .out_source           (out_source           )
  );

  // --------------------
  // Helpers
  // --------------------

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
      tests_failed++;
    end
  endtask

  // Entry in the top byte, requester in bits 23:20, sequence below
  function automatic req_word_t request_word(input int unsigned entry, input int unsigned src);
    return req_word_t'(((entry + 1) << 24) | (src << 20) | sent[src]);
  endfunction

  task automatic drive_requests(input logic [1:0] valid, input logic pop,
                                input int unsigned entry);
    req_valid = valid;
    out_pop   = pop;
    for (int i = 0; i < NUM_REQUESTERS; i++) begin
      req_data[i] = request_word(entry, i);
    end
  endtask

  function automatic int unsigned run_limit();
    int unsigned total;
    total = 0;
    for (int i = 0; i < NUM_JOBS; i++) begin
      total += int'(job_run[i]) + 40;
    end
    for (int i = 0; i < NUM_TRAFFIC; i++) begin
      total += traffic_cycles[i] + 40;
    end
    return total;
  endfunction

  // Requests off, pop until the FIFO runs dry
  task automatic drain_fifo();
    int unsigned waited;
    waited = 0;
    req_valid = '0;
    out_pop   = 1'b1;
    while (out_valid && waited <= FIFO_DEPTH + 2) begin
      @(negedge ap_clk);
      waited++;
    end
    out_pop = 1'b0;
    if (out_valid) begin
      $display("The FIFO did not drain within %0d cycles of popping", waited);
      error_count++;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  // Pre-edge values, so grants and pops match what the DUT samples
  always @(posedge ap_clk) begin : track_model
    logic [NUM_REQUESTERS-1:0] exp_grant;
    if (m_axi_areset) begin
      edges_since_reset = 0;
      last_src = 1'b1;
    end else begin
      check_value(out_valid, q_word.size() != 0, "out_valid against model");
      if (q_word.size() != 0) begin
        check_value(out_data, q_word[0], "out_data against model");
        check_value(out_source, q_src[0], "out_source against model");
      end
      // Round robin, no grant while busy or full
      exp_grant = '0;
      if (edges_since_reset >= FIFO_RESET_BUSY_CYCLES && q_word.size() < FIFO_DEPTH) begin
        if (req_valid == 2'b11) begin
          exp_grant = (last_src == 1'b1) ? 2'b01 : 2'b10;
        end else begin
          exp_grant = req_valid;
        end
      end
      check_value(req_grant, exp_grant, "req_grant");
      // Head leaves before the new word joins
      if (out_pop && q_word.size() != 0) begin
        void'(q_word.pop_front());
        void'(q_src.pop_front());
        popped++;
      end
      for (int i = 0; i < NUM_REQUESTERS; i++) begin
        if (req_grant[i]) begin
          q_word.push_back(req_data[i]);
          q_src.push_back(req_source_t'(i));
          last_src = req_source_t'(i);
          sent[i]++;
          accepted++;
        end
      end
      edges_since_reset++;
    end
  end

  // Watchdog
  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, control phase %s", cycle_limit, phase.name());
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // --------------------
  // Test tasks
  // --------------------

  task automatic run_job(input cycle_count_t run_cycles, input int unsigned desc_delay);
    int unsigned waited;
    int unsigned latency;
    int unsigned run;
    run    = int'(run_cycles);
    waited = 0;
    phase  = IDLE;
    ap_start = 1'b1;
    while (!ap_ready && waited < 20) begin
      @(negedge ap_clk);
      waited++;
    end
    ap_start = 1'b0;
    if (!ap_ready) begin
      $display("ap_ready did not rise within 20 cycles of ap_start");
      error_count++;
      return;
    end
    check_value(ap_idle, 0, "ap_idle with ap_ready");
    phase = BUSY;
    @(negedge ap_clk);
    check_value(ap_ready, 0, "ap_ready one cycle only");
    repeat (desc_delay) @(negedge ap_clk);
    // Descriptor strobe, one cycle
    descriptor_valid      = 1'b1;
    descriptor_run_cycles = run_cycles;
    @(negedge ap_clk);
    descriptor_valid = 1'b0;
    latency = 1;
    while (!ap_done && latency <= run + 3) begin
      @(negedge ap_clk);
      latency++;
    end
    if (!ap_done) begin
      $display("ap_done did not rise within %0d cycles of the descriptor", run + 3);
      error_count++;
      return;
    end
    check_value(latency >= run && latency <= run + 3, 1,
                $sformatf("ap_done latency %0d for run %0d", latency, run));
    // Done holds with continue low
    phase = DONE;
    repeat (3) begin
      @(negedge ap_clk);
      check_value(ap_done, 1, "ap_done hold");
    end
    ap_continue = 1'b1;
    @(negedge ap_clk);
    ap_continue = 1'b0;
    check_value(ap_done, 1, "ap_done while continue registers");
    check_value(ap_idle, 0, "ap_idle while continue registers");
    @(negedge ap_clk);
    check_value(ap_done, 0, "ap_done after continue");
    check_value(ap_idle, 1, "ap_idle after continue");
    phase = IDLE;
  endtask

  task automatic run_traffic(input int unsigned entry);
    int unsigned mode;
    int unsigned start_accepted;
    int unsigned start_popped;
    logic [31:0] r;
    mode = traffic_mode[entry];
    drain_fifo();
    start_accepted = accepted;
    for (int c = 0; c < traffic_cycles[entry]; c++) begin
      if (mode == MODE_RANDOM) begin
        r = $random(seed);
        drive_requests(r[1:0], r[2], entry);
      end else begin
        drive_requests(2'b11, mode == MODE_ALTERNATE, entry);
      end
      @(negedge ap_clk);
    end
    if (mode == MODE_ALTERNATE) begin
      // One push and one pop per cycle, never full
      check_value(accepted - start_accepted, traffic_cycles[entry], "words with pops");
    end else if (mode == MODE_BACKPRESSURE) begin
      check_value(accepted - start_accepted, FIFO_DEPTH, "words accepted while full");
      start_popped = popped;
      drain_fifo();
      check_value(popped - start_popped, FIFO_DEPTH, "words drained");
      // Grants come back once there is room
      start_accepted = accepted;
      repeat (4) begin
        drive_requests(2'b11, 1'b1, entry);
        @(negedge ap_clk);
      end
      check_value(accepted - start_accepted, 4, "grants after drain");
    end
    drain_fifo();
    check_value(q_word.size(), 0, "model queue empty");
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin : main_sequence
    int unsigned errors_before;
    int unsigned cycles;
    // Start and both requests held from reset
    ap_start              = 1'b1;
    ap_continue           = 1'b0;
    descriptor_valid      = 1'b0;
    descriptor_run_cycles = '0;
    drive_requests(2'b11, 1'b0, SETUP_ENTRY);
    cycle_limit = run_limit();

    @(negedge m_axi_areset);
    errors_before = error_count;
    check_value(ap_idle, 1, "ap_idle after reset");
    check_value(ap_ready, 0, "ap_ready after reset");
    check_value(ap_done, 0, "ap_done after reset");
    check_value(out_valid, 0, "out_valid after reset");
    check_value(req_grant, 0, "req_grant after reset");
    finish_test("reset values", errors_before);

    // No grant and no ap_ready in the busy window
    errors_before = error_count;
    cycles = 0;
    while (req_grant == '0 && cycles < FIFO_RESET_BUSY_CYCLES + 10) begin
      check_value(ap_ready, 0, "ap_ready during setup");
      @(negedge ap_clk);
      cycles++;
    end
    if (req_grant == '0) begin
      $display("No request grant within %0d cycles of reset", cycles);
      error_count++;
    end else begin
      check_value(cycles >= FIFO_RESET_BUSY_CYCLES, 1, "grant inside busy window");
      check_value(req_grant, 2'b01, "first grant after setup");
    end
    @(negedge ap_clk);
    drive_requests(2'b00, 1'b0, SETUP_ENTRY);
    finish_test("setup gating", errors_before);

    for (int j = 0; j < NUM_JOBS; j++) begin
      errors_before = error_count;
      run_job(job_run[j], job_delay[j]);
      finish_test($sformatf("job %0d run %0d", j, job_run[j]), errors_before);
    end

    for (int t = 0; t < NUM_TRAFFIC; t++) begin
      errors_before = error_count;
      run_traffic(t);
      finish_test($sformatf("traffic %0d mode %0d", t, traffic_mode[t]), errors_before);
    end

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : glay_kernel_cu_tb

`default_nettype wire

/* list.f */
src/glay_ctrl_pkg.sv
src/glay_req_pkg.sv
src/glay_control_input.sv
src/glay_kernel_control.sv
src/glay_req_arbiter.sv
src/glay_req_fifo.sv
src/glay_kernel_cu.sv
bench/glay_clock_gen.sv
bench/glay_kernel_cu_tb.sv

/* Makefile */
# Verilator build and run for the kernel compute unit testbench

TOP := glay_kernel_cu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP)

# Pass only if the testbench printed its pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
